//--- bench/coreTrace.txt
// op a b field result mispred, all hex, one program-order micro-op per line.
// field is the imm for ALU ops; for branches bit 15 is the predicted-taken flag.
9 00000064 00000007 0000 0000000e 0
0 00000005 00000007 0000 0000000c 0
1 00000010 00000003 0000 0000000d 0
2 f0f0f0f0 0ff00ff0 0000 00f000f0 0
3 12340000 00005678 0000 12345678 0
4 ffff0000 0f0f0f0f 0000 f0f00f0f 0
5 00000001 00000004 0000 00000010 0
6 80000000 0000001f 0000 00000001 0
0 00000064 00000000 fff6 0000005a 0
0 00000001 00000002 0003 00000006 0
1 00000000 00000001 0000 ffffffff 0
5 0000000f 00000008 0000 00000f00 0
6 0000f000 00000002 0002 00000f00 0
3 00000000 00000000 7fff 00007fff 0
2 ffffffff 00000010 fff0 00000000 0
0 7fffffff 00000001 0000 80000000 0
1 00000005 0000000a 0000 fffffffb 0
a 00000064 00000007 0000 00000002 0
9 00000011 00000000 0000 ffffffff 0
a 00000011 00000000 0000 00000011 0
7 00000004 00000004 8000 00000001 0
8 ffffffff 00000001 0000 00000001 1
0 00000003 00000004 0000 00000007 0
7 00000001 00000002 8000 00000000 1
8 00000005 fffffffe 0000 00000000 0
9 ffffffff 00000010 0000 0fffffff 0
0 00000001 00000001 0000 00000002 0
a 0000000a 00000003 0000 00000001 0

//--- sources.f
design/corePkg.sv
design/dispatchUnit.sv
design/intAlu.sv
design/divider.sv
design/branchSelector.sv
design/reorderBuffer.sv
design/coreTop.sv
bench/tbCore.sv

//--- Bender.yml
package:
  name: core_slice

sources:
  - design/corePkg.sv
  - design/dispatchUnit.sv
  - design/intAlu.sv
  - design/divider.sv
  - design/branchSelector.sv
  - design/reorderBuffer.sv
  - design/coreTop.sv
  - target: test
    files:
      - bench/tbCore.sv

//--- bench/tbCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCore import corePkg::*; ();

    logic                 clk;
    logic                 reset;
    logic                 dispReq;
    logic [opWidth-1:0]   dispOp;
    logic [dataWidth-1:0] dispA;
    logic [dataWidth-1:0] dispB;
    OpField               dispField;
    logic                 dispAck;
    logic                 redirect;
    logic [sqNWidth-1:0]  redirectSqN;
    logic                 commitValid;
    logic [sqNWidth-1:0]  commitSqN;
    logic [dataWidth-1:0] commitResult;

    logic [opWidth-1:0]   trOp[$];
    logic [dataWidth-1:0] trA[$];
    logic [dataWidth-1:0] trB[$];
    OpField               trField[$];
    logic [dataWidth-1:0] trExp[$];
    logic                 trMis[$];
    logic [dataWidth-1:0] expResults[$];

    integer seed = 32'h3b01_5f62;
    int traceLen = 0;
    bit traceLoaded = 1'b0;
    int errors = 0;
    int cycleNum = 0;
    int commitCount = 0;
    int redirectCount = 0;
    int lastRedirCycle = -1;
    int wrongOps = 0;
    int lateOps = 0;
    int withheldCount = 0;
    int mispredLines = 0;
    bit mispredPending = 1'b0;
    logic [sqNWidth-1:0] mispredSqN = '0;
    logic [sqNWidth-1:0] progSqN = '0;
    logic [sqNWidth-1:0] expCommitSqN = '0;

    coreTop dut0 (
        .clk, .reset,
        .dispReq, .dispOp, .dispA, .dispB, .dispField,
        .dispAck,
        .redirect, .redirectSqN,
        .commitValid, .commitSqN, .commitResult
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // **************************************************
    // Driver helpers
    // **************************************************
    // One cycle, sampled 1 ns after the edge. Every redirect passes through here.
    task automatic tick();
        @(posedge clk);
        #1;
        cycleNum++;
        if (redirect) begin
            assert (mispredPending) else begin
                errors++;
                $display("Redirect at %0t with no mispredicted branch outstanding", $time);
            end
            if (mispredPending) begin
                assert (redirectSqN == mispredSqN) else begin
                    errors++;
                    $display("ERROR %0t redirectSqN: got %0h expected %0h",
                        $time, redirectSqN, mispredSqN);
                end
            end
            mispredPending = 1'b0;
            redirectCount++;
            lastRedirCycle = cycleNum;
        end
    endtask

    // Four-phase request; returns the cycle in which dispAck was seen.
    task automatic sendOp(
        input  logic [opWidth-1:0]   op,
        input  logic [dataWidth-1:0] a,
        input  logic [dataWidth-1:0] b,
        input  OpField               field,
        output int                   ackCycle
    );
        int waited;
        assert (!dispAck) else begin
            errors++;
            $display("ERROR %0t dispAck: got 1 expected 0", $time);
        end
        dispOp = op;
        dispA = a;
        dispB = b;
        dispField = field;
        dispReq = 1'b1;
        tick();
        waited = 1;
        while (!dispAck) begin
            tick();
            waited++;
        end
        if (waited > 1) begin
            withheldCount++;
        end
        ackCycle = cycleNum;
        dispReq = 1'b0;
        tick();
        assert (!dispAck) else begin
            errors++;
            $display("ERROR %0t dispAck: got 1 expected 0", $time);
        end
    endtask

    // Wrong-path adds until the redirect for the branch shows up.
    task automatic runWrongPath(input int startCount);
        int gap;
        int sent;
        int ackCycle;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        sent = 0;
        while (redirectCount == startCount && sent < 8) begin
            gap = {$random(seed)} % 4;
            repeat (gap) begin
                if (redirectCount == startCount) begin
                    tick();
                end
            end
            if (redirectCount == startCount) begin
                a = $random(seed);
                b = $random(seed);
                sendOp(opAdd, a, b, '0, ackCycle);
                sent++;
                if (redirectCount != startCount && lastRedirCycle < ackCycle) begin
                    expResults.push_back(a + b);    // Taken after the flush, so it is real.
                    progSqN++;
                    lateOps++;
                end else begin
                    wrongOps++;
                end
            end
        end
        assert (redirectCount != startCount) else begin
            errors++;
            $display("No redirect came for the mispredicted branch at %0t", $time);
        end
    endtask

    // **************************************************
    // Commit monitor
    // **************************************************
    always @(negedge clk) begin
        if (!reset && commitValid) begin
            assert (expResults.size() > 0) else begin
                errors++;
                $display("Commit at %0t with no micro-op outstanding", $time);
            end
            if (expResults.size() > 0) begin
                assert (commitResult == expResults[0]) else begin
                    errors++;
                    $display("ERROR %0t commitResult: got %h expected %h",
                        $time, commitResult, expResults[0]);
                end
                void'(expResults.pop_front());
            end
            assert (commitSqN == expCommitSqN) else begin
                errors++;
                $display("ERROR %0t commitSqN: got %0h expected %0h",
                    $time, commitSqN, expCommitSqN);
            end
            expCommitSqN++;
            commitCount++;
        end
    end

    initial begin
        wait (traceLoaded);
        repeat (traceLen * (divCycles + 20) + 200) @(posedge clk);
        errors++;
        $display("Timeout: the run did not finish in time");
        $display("Done: %0d errors, %0d commits", errors, commitCount);
        $display("Simulation FAILED");
        $finish;
    end

    // **************************************************
    // Main sequence
    // **************************************************
    initial begin
        int fd;
        string line;
        logic [31:0] vOp;
        logic [31:0] vA;
        logic [31:0] vB;
        logic [31:0] vField;
        logic [31:0] vExp;
        logic [31:0] vMis;
        int ackCycle;
        int startCount;

        reset = 1'b1;
        dispReq = 1'b0;
        dispOp = '0;
        dispA = '0;
        dispB = '0;
        dispField = '0;

        fd = $fopen("bench/coreTrace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h %h %h %h", vOp, vA, vB, vField, vExp, vMis) == 6) begin
                    trOp.push_back(vOp[opWidth-1:0]);
                    trA.push_back(vA);
                    trB.push_back(vB);
                    trField.push_back(vField[15:0]);
                    trExp.push_back(vExp);
                    trMis.push_back(vMis[0]);
                end
            end
            $fclose(fd);
        end
        traceLen = trOp.size();
        traceLoaded = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!dispAck && !redirect && !commitValid) else begin
            errors++;
            $display("ERROR %0t dispAck redirect commitValid: got %b %b %b expected 0 0 0",
                $time, dispAck, redirect, commitValid);
        end

        for (int i = 0; i < traceLen; i++) begin
            startCount = redirectCount;
            if (trMis[i]) begin
                mispredSqN = progSqN;
                mispredPending = 1'b1;
                mispredLines++;
            end
            sendOp(trOp[i], trA[i], trB[i], trField[i], ackCycle);
            expResults.push_back(trExp[i]);
            progSqN++;
            if (trMis[i]) begin
                runWrongPath(startCount);
            end
        end

        while (commitCount < traceLen + lateOps) begin
            tick();
        end
        repeat (20) tick();    // Room for any stray commit.

        assert (commitCount == traceLen + lateOps && expResults.size() == 0) else begin
            errors++;
            $display("Commit count %0d does not match %0d dispatched micro-ops",
                commitCount, traceLen + lateOps);
        end
        assert (redirectCount == mispredLines) else begin
            errors++;
            $display("ERROR %0t redirectCount: got %0d expected %0d",
                $time, redirectCount, mispredLines);
        end
        assert (withheldCount > 0) else begin
            errors++;
            $display("dispAck was never withheld, the window never filled");
        end

        $display("Done: %0d errors, %0d commits, %0d wrong-path ops, %0d withheld requests",
            errors, commitCount, wrongOps, withheldCount);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/coreTop.sv
`timescale 1ns/1ps
`default_nettype none

module coreTop import corePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispReq,
    input  logic [opWidth-1:0]   dispOp,
    input  logic [dataWidth-1:0] dispA,
    input  logic [dataWidth-1:0] dispB,
    input  OpField               dispField,
    output logic                 dispAck,
    output logic                 redirect,
    output logic [sqNWidth-1:0]  redirectSqN,
    output logic                 commitValid,
    output logic [sqNWidth-1:0]  commitSqN,
    output logic [dataWidth-1:0] commitResult
);

    logic [numPorts-1:0]  issueValid;
    logic [opWidth-1:0]   issueOp;
    logic [dataWidth-1:0] issueA;
    logic [dataWidth-1:0] issueB;
    OpField               issueField;
    logic [sqNWidth-1:0]  issueSqN;
    logic                 allocValid;
    logic [sqNWidth-1:0]  allocSqN;
    logic [sqNWidth-1:0]  headSqN;
    logic                 divBusy;
    logic                 divDone;

    logic                 alu0WbValid;
    logic [sqNWidth-1:0]  alu0WbSqN;
    logic [dataWidth-1:0] alu0WbResult;
    logic                 alu0BrMispred;
    logic [sqNWidth-1:0]  alu0BrSqN;
    logic                 alu1WbValid;
    logic [sqNWidth-1:0]  alu1WbSqN;
    logic [dataWidth-1:0] alu1WbResult;
    logic                 alu1BrMispred;
    logic [sqNWidth-1:0]  alu1BrSqN;
    logic                 divWbValid;
    logic [sqNWidth-1:0]  divWbSqN;
    logic [dataWidth-1:0] divWbResult;
    logic                 wb0Valid;
    logic [sqNWidth-1:0]  wb0SqN;
    logic [dataWidth-1:0] wb0Result;

    // **************************************************
    // Dispatch and execution ports
    // **************************************************
    dispatchUnit dispatch0 (
        .clk, .reset,
        .dispReq, .dispOp, .dispA, .dispB, .dispField,
        .headSqN, .divBusy, .divDone,
        .redirect, .redirectSqN,
        .dispAck,
        .issueValid, .issueOp, .issueA, .issueB, .issueField, .issueSqN,
        .allocValid, .allocSqN
    );

    intAlu alu0 (
        .clk, .reset,
        .issueValid(issueValid[portAlu0]),
        .issueOp, .issueA, .issueB, .issueField, .issueSqN,
        .wbValid(alu0WbValid),
        .wbSqN(alu0WbSqN),
        .wbResult(alu0WbResult),
        .brMispred(alu0BrMispred),
        .brSqN(alu0BrSqN)
    );

    intAlu alu1 (
        .clk, .reset,
        .issueValid(issueValid[portAlu1]),
        .issueOp, .issueA, .issueB, .issueField, .issueSqN,
        .wbValid(alu1WbValid),
        .wbSqN(alu1WbSqN),
        .wbResult(alu1WbResult),
        .brMispred(alu1BrMispred),
        .brSqN(alu1BrSqN)
    );

    divider div0 (
        .clk, .reset,
        .issueValid(issueValid[portDiv]),
        .issueOp, .issueA, .issueB, .issueSqN,
        .redirect, .redirectSqN,
        .divBusy, .divDone,
        .wbValid(divWbValid),
        .wbSqN(divWbSqN),
        .wbResult(divWbResult)
    );

    // **************************************************
    // Redirect and commit
    // **************************************************
    branchSelector bsel0 (
        .clk, .reset,
        .brMispred0(alu0BrMispred),
        .brSqN0(alu0BrSqN),
        .brMispred1(alu1BrMispred),
        .brSqN1(alu1BrSqN),
        .redirect, .redirectSqN
    );

    // Divider never finishes while alu0 has a result.
    assign wb0Valid = alu0WbValid || divWbValid;
    assign wb0SqN = divWbValid ? divWbSqN : alu0WbSqN;
    assign wb0Result = divWbValid ? divWbResult : alu0WbResult;

    reorderBuffer rob0 (
        .clk, .reset,
        .allocValid, .allocSqN,
        .wbValid0(wb0Valid),
        .wbSqN0(wb0SqN),
        .wbResult0(wb0Result),
        .wbValid1(alu1WbValid),
        .wbSqN1(alu1WbSqN),
        .wbResult1(alu1WbResult),
        .redirect, .redirectSqN,
        .headSqN, .commitValid, .commitSqN, .commitResult
    );

endmodule

`default_nettype wire

//--- design/reorderBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer import corePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 allocValid,
    input  logic [sqNWidth-1:0]  allocSqN,
    input  logic                 wbValid0,
    input  logic [sqNWidth-1:0]  wbSqN0,
    input  logic [dataWidth-1:0] wbResult0,
    input  logic                 wbValid1,
    input  logic [sqNWidth-1:0]  wbSqN1,
    input  logic [dataWidth-1:0] wbResult1,
    input  logic                 redirect,
    input  logic [sqNWidth-1:0]  redirectSqN,
    output logic [sqNWidth-1:0]  headSqN,
    output logic                 commitValid,
    output logic [sqNWidth-1:0]  commitSqN,
    output logic [dataWidth-1:0] commitResult
);

    logic [robDepth-1:0]    entryValid;
    logic [robDepth-1:0]    entryDone;
    logic [dataWidth-1:0]   entryResult [robDepth];
    logic [robDepth-1:0]    flushMask;
    logic [robIdxWidth-1:0] headIdx;
    logic [robIdxWidth-1:0] allocIdx;
    logic [robIdxWidth-1:0] wbIdx0;
    logic [robIdxWidth-1:0] wbIdx1;
    logic [robIdxWidth-1:0] redirOff;
    logic                   wbOk0;
    logic                   wbOk1;
    logic                   headReady;

    assign headIdx = headSqN[robIdxWidth-1:0];
    assign allocIdx = allocSqN[robIdxWidth-1:0];
    assign wbIdx0 = wbSqN0[robIdxWidth-1:0];
    assign wbIdx1 = wbSqN1[robIdxWidth-1:0];
    assign redirOff = redirectSqN[robIdxWidth-1:0] - headIdx;

    // **************************************************
    // Flush by distance from the head
    // **************************************************
    always_comb begin
        logic [robIdxWidth-1:0] entryOff;
        for (int i = 0; i < robDepth; i++) begin
            entryOff = robIdxWidth'(i) - headIdx;
            flushMask[i] = redirect && entryOff > redirOff;
        end
    end

    assign wbOk0 = wbValid0 && entryValid[wbIdx0] && !flushMask[wbIdx0];
    assign wbOk1 = wbValid1 && entryValid[wbIdx1] && !flushMask[wbIdx1];
    assign headReady = entryValid[headIdx] && entryDone[headIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
            entryDone <= '0;
            headSqN <= '0;
            commitValid <= 1'b0;
        end else begin
            entryValid <= entryValid & ~flushMask;
            if (allocValid) begin
                entryValid[allocIdx] <= 1'b1;
                entryDone[allocIdx] <= 1'b0;
            end
            if (wbOk0) begin
                entryDone[wbIdx0] <= 1'b1;
            end
            if (wbOk1) begin
                entryDone[wbIdx1] <= 1'b1;
            end
            commitValid <= headReady;
            if (headReady) begin
                entryValid[headIdx] <= 1'b0;
                headSqN <= headSqN + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wbOk0) begin
            entryResult[wbIdx0] <= wbResult0;
        end
        if (wbOk1) begin
            entryResult[wbIdx1] <= wbResult1;
        end
        if (headReady) begin
            commitSqN <= headSqN;
            commitResult <= entryResult[headIdx];
        end
    end

endmodule

`default_nettype wire

//--- design/branchSelector.sv
`timescale 1ns/1ps
`default_nettype none

module branchSelector import corePkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                brMispred0,
    input  logic [sqNWidth-1:0] brSqN0,
    input  logic                brMispred1,
    input  logic [sqNWidth-1:0] brSqN1,
    output logic                redirect,
    output logic [sqNWidth-1:0] redirectSqN
);

    logic take0;
    logic take1;
    logic pick1;

    // Wrong-path branches behind the current redirect are ignored.
    assign take0 = brMispred0 && !(redirect && isYounger(brSqN0, redirectSqN));
    assign take1 = brMispred1 && !(redirect && isYounger(brSqN1, redirectSqN));
    assign pick1 = take1 && (!take0 || isYounger(brSqN0, brSqN1));

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect <= 1'b0;
        end else begin
            redirect <= take0 || take1;
        end
    end

    always_ff @(posedge clk) begin
        if (take0 || take1) begin
            redirectSqN <= pick1 ? brSqN1 : brSqN0;
        end
    end

endmodule

`default_nettype wire

//--- design/divider.sv
`timescale 1ns/1ps
`default_nettype none

module divider import corePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issueValid,
    input  logic [opWidth-1:0]   issueOp,
    input  logic [dataWidth-1:0] issueA,
    input  logic [dataWidth-1:0] issueB,
    input  logic [sqNWidth-1:0]  issueSqN,
    input  logic                 redirect,
    input  logic [sqNWidth-1:0]  redirectSqN,
    output logic                 divBusy,
    output logic                 divDone,
    output logic                 wbValid,
    output logic [sqNWidth-1:0]  wbSqN,
    output logic [dataWidth-1:0] wbResult
);

    logic [divCntWidth-1:0] count;
    logic                   isRem;
    logic [sqNWidth-1:0]    opSqN;
    logic                   abort;
    logic [dataWidth-1:0]   quot;
    logic [dataWidth-1:0]   rem;
    logic [dataWidth-1:0]   divisor;
    logic [dataWidth:0]     remShift;
    logic [dataWidth:0]     trial;
    logic [dataWidth-1:0]   quotNext;
    logic [dataWidth-1:0]   remNext;

    // **************************************************
    // One restoring step per cycle
    // **************************************************
    assign remShift = {rem, quot[dataWidth-1]};
    assign trial = remShift - {1'b0, divisor};
    assign quotNext = {quot[dataWidth-2:0], !trial[dataWidth]};
    assign remNext = trial[dataWidth] ? remShift[dataWidth-1:0] : trial[dataWidth-1:0];

    assign divDone = divBusy && count == divCntWidth'(divCycles - 1);
    assign abort = redirect && isYounger(opSqN, redirectSqN);

    always_ff @(posedge clk) begin
        if (reset) begin
            divBusy <= 1'b0;
            count <= '0;
            wbValid <= 1'b0;
        end else begin
            wbValid <= divDone && !abort;
            if (divBusy) begin
                count <= count + 1'b1;
                if (abort || divDone) begin
                    divBusy <= 1'b0;
                end
            end else if (issueValid) begin
                divBusy <= 1'b1;
                count <= '0;
            end
        end
    end

    // Zero divisor leaves all ones in quot and the dividend in rem.
    always_ff @(posedge clk) begin
        if (issueValid && !divBusy) begin
            quot <= issueA;
            rem <= '0;
            divisor <= issueB;
            isRem <= issueOp == opRem;
            opSqN <= issueSqN;
        end else if (divBusy) begin
            quot <= quotNext;
            rem <= remNext;
        end
        if (divDone) begin
            wbSqN <= opSqN;
            wbResult <= isRem ? remNext : quotNext;
        end
    end

endmodule

`default_nettype wire

//--- design/intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu import corePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issueValid,
    input  logic [opWidth-1:0]   issueOp,
    input  logic [dataWidth-1:0] issueA,
    input  logic [dataWidth-1:0] issueB,
    input  OpField               issueField,
    input  logic [sqNWidth-1:0]  issueSqN,
    output logic                 wbValid,
    output logic [sqNWidth-1:0]  wbSqN,
    output logic [dataWidth-1:0] wbResult,
    output logic                 brMispred,
    output logic [sqNWidth-1:0]  brSqN
);

    logic                 isBranch;
    logic                 taken;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] result;

    assign isBranch = issueOp == opBeq || issueOp == opBlt;
    assign immExt = {{(dataWidth-16){issueField.imm[15]}}, issueField.imm};
    assign srcB = isBranch ? issueB : issueB + immExt;    // Branch view holds no imm.

    always_comb begin
        taken = 1'b0;
        result = '0;
        case (issueOp)
            opAdd: result = issueA + srcB;
            opSub: result = issueA - srcB;
            opAnd: result = issueA & srcB;
            opOr: result = issueA | srcB;
            opXor: result = issueA ^ srcB;
            opSll: result = issueA << srcB[$clog2(dataWidth)-1:0];
            opSrl: result = issueA >> srcB[$clog2(dataWidth)-1:0];
            opBeq: taken = issueA == srcB;
            opBlt: taken = $signed(issueA) < $signed(srcB);
            default: result = '0;
        endcase
        if (isBranch) begin
            result = {{(dataWidth-1){1'b0}}, taken};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid <= 1'b0;
            brMispred <= 1'b0;
        end else begin
            wbValid <= issueValid;
            brMispred <= issueValid && isBranch && taken != issueField.branch.predTaken;
        end
    end

    always_ff @(posedge clk) begin
        wbSqN <= issueSqN;
        wbResult <= result;
        brSqN <= issueSqN;
    end

endmodule

`default_nettype wire

//--- design/dispatchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchUnit import corePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispReq,
    input  logic [opWidth-1:0]   dispOp,
    input  logic [dataWidth-1:0] dispA,
    input  logic [dataWidth-1:0] dispB,
    input  OpField               dispField,
    input  logic [sqNWidth-1:0]  headSqN,
    input  logic                 divBusy,
    input  logic                 divDone,
    input  logic                 redirect,
    input  logic [sqNWidth-1:0]  redirectSqN,
    output logic                 dispAck,
    output logic [numPorts-1:0]  issueValid,
    output logic [opWidth-1:0]   issueOp,
    output logic [dataWidth-1:0] issueA,
    output logic [dataWidth-1:0] issueB,
    output OpField               issueField,
    output logic [sqNWidth-1:0]  issueSqN,
    output logic                 allocValid,
    output logic [sqNWidth-1:0]  allocSqN
);

    logic [sqNWidth-1:0]  nextSqN;
    logic [sqNWidth-1:0]  inFlight;
    logic                 windowFull;
    logic                 dispIsDiv;
    logic                 divBlock;
    logic                 accept;

    logic                 pendValid;
    logic [opWidth-1:0]   pendOp;
    logic [dataWidth-1:0] pendA;
    logic [dataWidth-1:0] pendB;
    OpField               pendField;
    logic [sqNWidth-1:0]  pendSqN;
    logic                 pendIsDiv;
    logic [numPorts-1:0]  pendPort;
    logic                 toAlu1;

    logic [numPorts-1:0]  issueValidQ;
    logic                 hold;
    logic                 kill;
    logic                 issueStall;

    // **************************************************
    // Acceptance
    // **************************************************
    assign inFlight = nextSqN - headSqN;
    assign windowFull = inFlight >= robDepth;
    assign dispIsDiv = dispOp == opDiv || dispOp == opRem;
    assign pendIsDiv = pendOp == opDiv || pendOp == opRem;
    assign divBlock = divBusy || issueValidQ[portDiv];
    assign accept = dispReq && !dispAck && !pendValid && !redirect && !windowFull
        && !(dispIsDiv && divBlock);

    assign pendPort = pendIsDiv ? numPorts'(1) << portDiv
        : toAlu1 ? numPorts'(1) << portAlu1 : numPorts'(1) << portAlu0;

    // **************************************************
    // Issue stage
    // **************************************************
    assign hold = issueValidQ[portAlu0] && divDone;    // Port 0 belongs to the divider.
    assign kill = redirect && isYounger(issueSqN, redirectSqN);
    assign issueStall = hold && !kill;
    assign issueValid = (hold || kill) ? '0 : issueValidQ;
    assign allocValid = |issueValid;
    assign allocSqN = issueSqN;

    always_ff @(posedge clk) begin
        if (reset) begin
            dispAck <= 1'b0;
            pendValid <= 1'b0;
            issueValidQ <= '0;
            nextSqN <= '0;
            toAlu1 <= 1'b0;
        end else begin
            if (accept) begin
                dispAck <= 1'b1;
            end else if (!dispReq) begin
                dispAck <= 1'b0;
            end

            if (accept) begin
                pendValid <= 1'b1;
            end else if (redirect || !issueStall) begin
                pendValid <= 1'b0;                  // Ack in a redirect cycle is lost.
            end

            if (!issueStall) begin
                issueValidQ <= (pendValid && !redirect) ? pendPort : '0;
                if (pendValid && !redirect && !pendIsDiv) begin
                    toAlu1 <= !toAlu1;
                end
            end

            if (redirect) begin
                nextSqN <= redirectSqN + 1'b1;
            end else if (accept) begin
                nextSqN <= nextSqN + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pendOp <= dispOp;
            pendA <= dispA;
            pendB <= dispB;
            pendField <= dispField;
            pendSqN <= nextSqN;
        end
        if (pendValid && !issueStall) begin
            issueOp <= pendOp;
            issueA <= pendA;
            issueB <= pendB;
            issueField <= pendField;
            issueSqN <= pendSqN;
        end
    end

endmodule

`default_nettype wire

//--- design/corePkg.sv
`default_nettype none

package corePkg;

    localparam int dataWidth = 32;
    localparam int robDepth = 16;
    localparam int robIdxWidth = $clog2(robDepth);
    localparam int sqNWidth = 7;
    localparam int numPorts = 3;
    localparam int opWidth = 4;
    localparam int divCycles = 32;
    localparam int divCntWidth = $clog2(divCycles);

    localparam int portAlu0 = 0;
    localparam int portAlu1 = 1;
    localparam int portDiv = 2;

    localparam logic [opWidth-1:0] opAdd = 4'h0;
    localparam logic [opWidth-1:0] opSub = 4'h1;
    localparam logic [opWidth-1:0] opAnd = 4'h2;
    localparam logic [opWidth-1:0] opOr = 4'h3;
    localparam logic [opWidth-1:0] opXor = 4'h4;
    localparam logic [opWidth-1:0] opSll = 4'h5;
    localparam logic [opWidth-1:0] opSrl = 4'h6;
    localparam logic [opWidth-1:0] opBeq = 4'h7;
    localparam logic [opWidth-1:0] opBlt = 4'h8;   // Signed compare.
    localparam logic [opWidth-1:0] opDiv = 4'h9;
    localparam logic [opWidth-1:0] opRem = 4'ha;

    typedef union packed {
        logic [15:0] imm;                  // Sign-extended, added to operand B.
        struct packed {
            logic predTaken;
            logic [14:0] reserved;
        } branch;
    } OpField;

    // Sequence numbers wrap, so age is the sign of the difference.
    function automatic logic isYounger(
        input logic [sqNWidth-1:0] a,
        input logic [sqNWidth-1:0] b
    );
        logic signed [sqNWidth-1:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

endpackage

`default_nettype wire
